/* bimodal/bimodal_table.sv */
`timescale 1ns/1ns

module bimodal_table import bpu_pkg::*; #(
    parameter int BHT_ENTRIES = 512
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] rd_pc_i,
    output logic            taken_o,
    input  logic            train_i,
    input  logic [XLEN-1:0] wr_pc_i,
    input  logic            outcome_i
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    ctr_t             ctr_q [BHT_ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    ctr_t             wr_ctr;
    ctr_t             wr_ctr_next;

    // halfword granularity, bit 0 dropped
    assign rd_idx = rd_pc_i[IDX_W:1];
    assign wr_idx = wr_pc_i[IDX_W:1];

    assign taken_o = ctr_q[rd_idx][1];

    assign wr_ctr = ctr_q[wr_idx];

    // one step toward the outcome, saturating
    always_comb begin
        wr_ctr_next = wr_ctr;
        if (outcome_i && (wr_ctr != 2'b11)) begin
            wr_ctr_next = wr_ctr + 2'b01;
        end else if (!outcome_i && (wr_ctr != 2'b00)) begin
            wr_ctr_next = wr_ctr - 2'b01;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ctr_q[i] <= CTR_INIT;
            end
        end else if (train_i) begin
            ctr_q[wr_idx] <= wr_ctr_next;
        end
    end

endmodule

/* bpu_top.f */
+incdir+sim
common/bpu_pkg.sv
src/rv_cf_decode.sv
bimodal/bimodal_table.sv
btb/branch_target_buffer.sv
ras/return_stack.sv
src/bpu_top.sv
sim/bpu_tb.sv

/* btb/branch_target_buffer.sv */
`timescale 1ns/1ns

module branch_target_buffer import bpu_pkg::*; #(
    parameter int BTB_ENTRIES   = 256,
    parameter int BTB_TAG_WIDTH = 14
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] rd_pc_i,
    output logic            hit_o,
    output logic [XLEN-1:0] target_o,
    input  logic            fill_i,
    input  logic [XLEN-1:0] wr_pc_i,
    input  logic [XLEN-1:0] wr_target_i
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);

    logic                     valid_q [BTB_ENTRIES];
    logic [BTB_TAG_WIDTH-1:0] tag_mem [BTB_ENTRIES];
    logic [XLEN-1:0]          target_mem [BTB_ENTRIES];

    logic [IDX_W-1:0]         rd_idx;
    logic [IDX_W-1:0]         wr_idx;
    logic [BTB_TAG_WIDTH-1:0] rd_tag;
    logic [BTB_TAG_WIDTH-1:0] wr_tag;

    // word index, tag from the top of the pc
    assign rd_idx = rd_pc_i[IDX_W+1:2];
    assign wr_idx = wr_pc_i[IDX_W+1:2];
    assign rd_tag = rd_pc_i[XLEN-1 -: BTB_TAG_WIDTH];
    assign wr_tag = wr_pc_i[XLEN-1 -: BTB_TAG_WIDTH];

    assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target_o = target_mem[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // payload, qualified by valid_q
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= wr_target_i;
        end
    end

    hit_needs_valid: assert property (@(posedge clk) disable iff (rst)
        hit_o |-> valid_q[rd_idx]);

endmodule

/* common/bpu_pkg.sv */
package bpu_pkg;

    localparam int XLEN = 32;

    // major opcodes of the control-flow classes
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [4:0] REG_RA = 5'd1;  // x1, link register

    typedef logic [1:0] ctr_t;  // msb is the taken bit

    localparam ctr_t CTR_INIT = 2'b01;  // weakly not-taken

    // one instruction word, seen as B-type or as J-type
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_u;

endpackage

/* ras/return_stack.sv */
`timescale 1ns/1ns

module return_stack import bpu_pkg::*; #(
    parameter int RAS_DEPTH = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            push_i,
    input  logic [XLEN-1:0] call_pc_i,
    input  logic            pop_i,
    input  logic            id_push_i,
    input  logic [XLEN-1:0] id_addr_i,
    output logic            top_valid_o,
    output logic [XLEN-1:0] top_addr_o,
    output logic            pend_valid_o,
    output logic [XLEN-1:0] pend_addr_o
);

    localparam int PTR_W = $clog2(RAS_DEPTH);

    logic [XLEN-1:0]  stack_mem [RAS_DEPTH];
    logic [PTR_W:0]   count_q;  // one extra bit to hold RAS_DEPTH
    logic [PTR_W-1:0] top_idx;
    logic [PTR_W-1:0] push_idx;
    logic             full;
    logic             pend_valid_q;
    logic [XLEN-1:0]  pend_addr_q;

    assign full     = (count_q == (PTR_W+1)'(RAS_DEPTH));
    assign top_idx  = PTR_W'(count_q - 1'b1);
    assign push_idx = count_q[PTR_W-1:0];  // wraps to the bottom when full

    assign top_valid_o  = (count_q != '0);
    assign top_addr_o   = stack_mem[top_idx];
    assign pend_valid_o = pend_valid_q;
    assign pend_addr_o  = pend_addr_q;

    // call and return never come from the same word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
        end else if (push_i) begin
            count_q <= full ? (PTR_W+1)'(1) : count_q + 1'b1;
        end else if (pop_i && top_valid_o) begin
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_mem[push_idx] <= call_pc_i + XLEN'(4);
        end
    end

    // decode-stage push, lives for one cycle only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_valid_q <= 1'b0;
        end else begin
            pend_valid_q <= id_push_i && !flush_i;  // flush wins
        end
    end

    always_ff @(posedge clk) begin
        if (id_push_i) begin
            pend_addr_q <= id_addr_i;
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        count_q <= (PTR_W+1)'(RAS_DEPTH));

endmodule

/* sim/bpu_tb_cases.svh */
// name, fetch pc, fetch word, id push, id addr, ex valid, ex pc, ex word, ex taken,
// ex target, flush, then the expected is_cf, taken and next pc
task automatic load_cases();
    add_case("nop_pc4", 'h1000, NOP, 0, 0, 0, 0, NOP, 0, 0, 0, 0, 0, 'h1004);
    add_case("br_cold", 'h2000, BEQ_N, 0, 0, 1, 'h2000, BEQ_N, 1, 'h3000, 0, 1, 0, 'h2004);
    add_case("jal_cold_pos", 'h1100, JAL_P, 0, 0, 1, 'h2000, BEQ_N, 1, 'h3000, 0, 1, 1, 'h1200);
    add_case("jal_cold_neg", 'h1180, JAL_N, 0, 0, 0, 0, NOP, 0, 0, 0, 1, 1, 'h1178);
    // counter saturated, btb filled
    add_case("br_trained", 'h2000, BEQ_N, 0, 0, 1, 'h2000, BEQ_N, 0, 0, 0, 1, 1, 'h3000);
    add_case("br_alias", 'h42000, BEQ_N, 0, 0, 1, 'h2000, BEQ_N, 0, 0, 0, 1, 1, 'h41ff0);
    add_case("br_untrained", 'h2000, BEQ_N, 0, 0, 0, 0, NOP, 0, 0, 0, 1, 0, 'h2004);
    add_case("jalr_cold", 'h1404, JR_T0, 0, 0, 1, 'h1404, JR_T0, 1, 'h5550, 0, 1, 0, 'h1408);
    add_case("jalr_hit", 'h1404, JR_T0, 0, 0, 0, 0, NOP, 0, 0, 0, 1, 1, 'h5550);
    add_case("jalr_alias", 'h41404, JR_T0, 0, 0, 0, 0, NOP, 0, 0, 0, 1, 0, 'h41408);
    // three calls, then three returns
    add_case("ret_cold", 'h3204, RET, 0, 0, 1, 'h3010, CALL, 1, 'h3110, 0, 1, 1, 'h0);
    add_case("call1_top", 'h3204, RET, 0, 0, 1, 'h3020, CALL, 1, 'h3120, 0, 1, 1, 'h3014);
    add_case("call2_top", 'h3204, RET, 0, 0, 1, 'h3030, CALL, 1, 'h3130, 0, 1, 1, 'h3024);
    add_case("ret_c3", 'h3204, RET, 0, 0, 1, 'h3204, RET, 1, 'h3034, 0, 1, 1, 'h3034);
    add_case("ret_c2", 'h3204, RET, 0, 0, 1, 'h3204, RET, 1, 'h3024, 0, 1, 1, 'h3024);
    add_case("ret_c1", 'h3204, RET, 0, 0, 1, 'h3204, RET, 1, 'h3014, 0, 1, 1, 'h3014);
    add_case("ret_btb", 'h3204, RET, 0, 0, 1, 'h3204, RET, 1, 'h3014, 0, 1, 1, 'h3014);
    add_case("pop_empty", 'h3204, RET, 0, 0, 1, 'h3410, CALL, 1, 'h3510, 0, 1, 1, 'h3014);
    // five calls into a four deep stack
    add_case("ovf_call1", 'h3204, RET, 0, 0, 1, 'h3420, CALL, 1, 'h3520, 0, 1, 1, 'h3414);
    add_case("ovf_call2", 'h3204, RET, 0, 0, 1, 'h3430, CALL, 1, 'h3530, 0, 1, 1, 'h3424);
    add_case("ovf_call3", 'h3204, RET, 0, 0, 1, 'h3440, CALL, 1, 'h3540, 0, 1, 1, 'h3434);
    add_case("ovf_full", 'h3204, RET, 0, 0, 1, 'h3450, CALL, 1, 'h3550, 0, 1, 1, 'h3444);
    add_case("ovf_wrap", 'h3204, RET, 0, 0, 1, 'h3204, RET, 1, 'h3454, 0, 1, 1, 'h3454);
    // pending slot
    add_case("pend_push", 'h3500, NOP, 1, 'h7770, 0, 0, NOP, 0, 0, 0, 0, 0, 'h3504);
    add_case("pend_ret", 'h3608, RET, 0, 0, 0, 0, NOP, 0, 0, 0, 1, 1, 'h7770);
    add_case("pend_gone", 'h3204, RET, 0, 0, 0, 0, NOP, 0, 0, 0, 1, 1, 'h3454);
    add_case("flush_push", 'h3500, NOP, 1, 'h8880, 0, 0, NOP, 0, 0, 1, 0, 0, 'h3504);
    add_case("flush_ret", 'h3608, RET, 0, 0, 0, 0, NOP, 0, 0, 0, 1, 1, 'h0);
endtask

/* sim/bpu_tb.sv */
`timescale 1ns/1ns

module bpu_tb;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 4;
    localparam int SLACK      = 20;
    localparam int MAX_CASES  = 64;

    localparam logic [31:0] NOP   = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] BEQ_N = 32'hfe00_08e3;  // beq x0, x0, -16
    localparam logic [31:0] JAL_P = 32'h1000_006f;  // jal x0, +256
    localparam logic [31:0] JAL_N = 32'hff9f_f06f;  // jal x0, -8
    localparam logic [31:0] CALL  = 32'h1000_00ef;  // jal ra, +256
    localparam logic [31:0] JR_T0 = 32'h0002_8067;  // jalr x0, 0(t0)
    localparam logic [31:0] RET   = 32'h0000_8067;  // jalr x0, 0(ra)

    logic        clk = 1'b0;
    logic        rst;
    logic        flush;
    logic [31:0] if_pc;
    logic [31:0] if_inst;
    logic        id_push;
    logic [31:0] id_addr;
    logic        ex_valid;
    logic [31:0] ex_pc;
    logic [31:0] ex_inst;
    logic        ex_taken;
    logic [31:0] ex_target;
    logic        is_cf;
    logic        pdt_taken;
    logic [31:0] pdt_pc;

    // case table
    string       name_tab [MAX_CASES];
    logic [31:0] pc_tab [MAX_CASES];
    logic [31:0] inst_tab [MAX_CASES];
    logic        idp_tab [MAX_CASES];
    logic [31:0] ida_tab [MAX_CASES];
    logic        exv_tab [MAX_CASES];
    logic [31:0] expc_tab [MAX_CASES];
    logic [31:0] exinst_tab [MAX_CASES];
    logic        ext_tab [MAX_CASES];
    logic [31:0] extgt_tab [MAX_CASES];
    logic        flush_tab [MAX_CASES];
    logic        cf_exp [MAX_CASES];
    logic        taken_exp [MAX_CASES];
    logic [31:0] pc_exp [MAX_CASES];
    int          n_cases = 0;
    int          cycles = 0;

    bpu_top #(.RAS_DEPTH(4)) dut0 (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush),
        .if_pc_i       (if_pc),
        .if_inst_i     (if_inst),
        .id_ras_push_i (id_push),
        .id_ras_addr_i (id_addr),
        .ex_valid_i    (ex_valid),
        .ex_pc_i       (ex_pc),
        .ex_inst_i     (ex_inst),
        .ex_taken_i    (ex_taken),
        .ex_target_i   (ex_target),
        .is_cf_o       (is_cf),
        .pdt_taken_o   (pdt_taken),
        .pdt_pc_o      (pdt_pc)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic add_case(input string name, input logic [31:0] pc, input logic [31:0] inst,
                            input logic idp, input logic [31:0] ida, input logic exv,
                            input logic [31:0] expc, input logic [31:0] exinst,
                            input logic ext, input logic [31:0] extgt, input logic fl,
                            input logic ecf, input logic etk, input logic [31:0] epc);
        name_tab[n_cases]   = name;
        pc_tab[n_cases]     = pc;
        inst_tab[n_cases]   = inst;
        idp_tab[n_cases]    = idp;
        ida_tab[n_cases]    = ida;
        exv_tab[n_cases]    = exv;
        expc_tab[n_cases]   = expc;
        exinst_tab[n_cases] = exinst;
        ext_tab[n_cases]    = ext;
        extgt_tab[n_cases]  = extgt;
        flush_tab[n_cases]  = fl;
        cf_exp[n_cases]     = ecf;
        taken_exp[n_cases]  = etk;
        pc_exp[n_cases]     = epc;
        n_cases++;
    endtask

    `include "bpu_tb_cases.svh"

    task automatic drive_row(input int i);
        if_pc     = pc_tab[i];
        if_inst   = inst_tab[i];
        id_push   = idp_tab[i];
        id_addr   = ida_tab[i];
        ex_valid  = exv_tab[i];
        ex_pc     = expc_tab[i];
        ex_inst   = exinst_tab[i];
        ex_taken  = ext_tab[i];
        ex_target = extgt_tab[i];
        flush     = flush_tab[i];
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error %s %s: expected %h, actual %h", name, what, expected, actual);
            $display("Regression failed");
            $fatal(1, "wrong value in case %s", name);
        end
    endtask

    // guards against a stuck run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > n_cases + RST_CYCLES + SLACK) begin
            $display("Regression failed");
            $fatal(1, "timeout, case table did not finish");
        end
    end

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        if_pc     = '0;
        if_inst   = NOP;
        id_push   = 1'b0;
        id_addr   = '0;
        ex_valid  = 1'b0;
        ex_pc     = '0;
        ex_inst   = NOP;
        ex_taken  = 1'b0;
        ex_target = '0;
        load_cases();
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < n_cases; i++) begin
            @(posedge clk);
            #1;
            drive_row(i);
            #(CLK_PERIOD - 2);  // just before the next edge
            check_value(name_tab[i], "is_cf", 32'(cf_exp[i]), 32'(is_cf));
            check_value(name_tab[i], "taken", 32'(taken_exp[i]), 32'(pdt_taken));
            check_value(name_tab[i], "next_pc", pc_exp[i], pdt_pc);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* src/bpu_top.sv */
`timescale 1ns/1ns

module bpu_top import bpu_pkg::*; #(
    parameter int RAS_DEPTH     = 32,
    parameter int BHT_ENTRIES   = 512,
    parameter int BTB_ENTRIES   = 256,
    parameter int BTB_TAG_WIDTH = 14
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic [XLEN-1:0] if_pc_i,
    input  logic [XLEN-1:0] if_inst_i,
    input  logic            id_ras_push_i,
    input  logic [XLEN-1:0] id_ras_addr_i,
    input  logic            ex_valid_i,
    input  logic [XLEN-1:0] ex_pc_i,
    input  logic [XLEN-1:0] ex_inst_i,
    input  logic            ex_taken_i,
    input  logic [XLEN-1:0] ex_target_i,
    output logic            is_cf_o,
    output logic            pdt_taken_o,
    output logic [XLEN-1:0] pdt_pc_o
);

    logic            if_is_branch;
    logic            if_is_jal;
    logic            if_is_jalr;
    logic            if_is_ret;
    logic [XLEN-1:0] if_br_off;
    logic [XLEN-1:0] if_jal_off;
    logic            ex_is_branch;
    logic            ex_is_jal;
    logic            ex_is_jalr;
    logic            ex_is_call;
    logic            ex_is_ret;
    logic            ex_cf;
    logic            bht_taken;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic            ras_top_valid;
    logic [XLEN-1:0] ras_top_addr;
    logic            ras_pend_valid;
    logic [XLEN-1:0] ras_pend_addr;
    logic [XLEN-1:0] pc_plus4;

    rv_cf_decode if_dec (
        .inst_i      (if_inst_i),
        .is_branch_o (if_is_branch),
        .is_jal_o    (if_is_jal),
        .is_jalr_o   (if_is_jalr),
        .is_call_o   (),
        .is_ret_o    (if_is_ret),
        .br_off_o    (if_br_off),
        .jal_off_o   (if_jal_off)
    );

    rv_cf_decode ex_dec (
        .inst_i      (ex_inst_i),
        .is_branch_o (ex_is_branch),
        .is_jal_o    (ex_is_jal),
        .is_jalr_o   (ex_is_jalr),
        .is_call_o   (ex_is_call),
        .is_ret_o    (ex_is_ret),
        .br_off_o    (),
        .jal_off_o   ()
    );

    assign ex_cf = ex_is_branch | ex_is_jal | ex_is_jalr;

    bimodal_table #(.BHT_ENTRIES(BHT_ENTRIES)) bht0 (
        .clk       (clk),
        .rst       (rst),
        .rd_pc_i   (if_pc_i),
        .taken_o   (bht_taken),
        .train_i   (ex_valid_i & ex_cf),
        .wr_pc_i   (ex_pc_i),
        .outcome_i (ex_taken_i)
    );

    branch_target_buffer #(
        .BTB_ENTRIES   (BTB_ENTRIES),
        .BTB_TAG_WIDTH (BTB_TAG_WIDTH)
    ) btb0 (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .fill_i      (ex_valid_i & ex_cf & ex_taken_i),
        .wr_pc_i     (ex_pc_i),
        .wr_target_i (ex_target_i)
    );

    return_stack #(.RAS_DEPTH(RAS_DEPTH)) ras0 (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .push_i       (ex_valid_i & ex_is_call),
        .call_pc_i    (ex_pc_i),
        .pop_i        (ex_valid_i & ex_is_ret),
        .id_push_i    (id_ras_push_i),
        .id_addr_i    (id_ras_addr_i),
        .top_valid_o  (ras_top_valid),
        .top_addr_o   (ras_top_addr),
        .pend_valid_o (ras_pend_valid),
        .pend_addr_o  (ras_pend_addr)
    );

    assign pc_plus4 = if_pc_i + XLEN'(4);

    always_comb begin
        is_cf_o     = if_is_branch | if_is_jal | if_is_jalr;
        pdt_taken_o = 1'b0;
        pdt_pc_o    = pc_plus4;
        if (if_is_ret) begin
            pdt_taken_o = 1'b1;
            if (ras_top_valid) begin
                pdt_pc_o = ras_top_addr;
            end else if (ras_pend_valid) begin
                pdt_pc_o = ras_pend_addr;  // call still in flight
            end else if (btb_hit) begin
                pdt_pc_o = btb_target;
            end else begin
                pdt_pc_o = '0;
            end
        end else if (if_is_jalr) begin
            if (btb_hit) begin  // no target known otherwise
                pdt_taken_o = 1'b1;
                pdt_pc_o    = btb_target;
            end
        end else if (if_is_jal) begin
            pdt_taken_o = 1'b1;
            pdt_pc_o    = btb_hit ? btb_target : if_pc_i + if_jal_off;
        end else if (if_is_branch && bht_taken) begin
            pdt_taken_o = 1'b1;
            pdt_pc_o    = btb_hit ? btb_target : if_pc_i + if_br_off;
        end
    end

endmodule

/* src/rv_cf_decode.sv */
`timescale 1ns/1ns

module rv_cf_decode import bpu_pkg::*; (
    input  logic [XLEN-1:0] inst_i,
    output logic            is_branch_o,
    output logic            is_jal_o,
    output logic            is_jalr_o,
    output logic            is_call_o,
    output logic            is_ret_o,
    output logic [XLEN-1:0] br_off_o,
    output logic [XLEN-1:0] jal_off_o
);

    inst_u inst;
    logic  rd_zero;

    assign inst = inst_i;

    // rd sits at [11:7] for both I-type and J-type
    assign rd_zero = (inst.j.rd == 5'd0);

    assign is_branch_o = (inst.b.opcode == OPC_BRANCH);
    assign is_jal_o    = (inst.j.opcode == OPC_JAL);
    assign is_jalr_o   = (inst.b.opcode == OPC_JALR);

    // jalr x0, 0(ra)
    assign is_ret_o  = is_jalr_o && rd_zero && (inst.b.rs1 == REG_RA);
    assign is_call_o = is_jal_o || (is_jalr_o && !rd_zero);

    // immediates are halfword offsets, bit 0 always zero
    assign br_off_o = {
        {(XLEN-12){inst.b.imm12}},
        inst.b.imm11,
        inst.b.imm10_5,
        inst.b.imm4_1,
        1'b0
    };

    assign jal_off_o = {
        {(XLEN-20){inst.j.imm20}},
        inst.j.imm19_12,
        inst.j.imm11,
        inst.j.imm10_1,
        1'b0
    };

    // classes come from distinct opcodes
    cf_class_onehot: assert final ($onehot0({is_branch_o, is_jal_o, is_jalr_o}))
        else $error("rv_cf_decode: more than one control-flow class for %h", inst_i);

endmodule
